// File: compile.f
+incdir+source
source/bus_pkg.sv
source/addr_decoder.sv
source/port_arbiter.sv
source/sram_controller.sv
source/serial_regs.sv
source/memory_bus_top.sv
test/sram_model.sv
test/tb_memory_bus.sv

// File: Makefile
# Verilator build and run of the memory bus testbench

TOP = tb_memory_bus

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f compile.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// File: test/bus_testdata.txt
# name port kind inst_addr data_addr wdata mask exp_inst exp_data stall (hex, stall decimal)
# rx takes its byte from wdata; rx and idle expect irq in exp_data, serial writes the tx byte
wb_full  data wr 0        80001000 11223344 f 0        0        0
wb_part  data wr 0        80001000 aabbccdd 5 0        0        0
rb_part  data rd 0        80001000 0        f 0        11bb33dd 0
wb_full2 data wr 0        80001004 deadbeef f 0        0        0
wb_top   data wr 0        80001004 99000000 8 0        0        0
rb_top   data rd 0        80001004 0        f 0        99adbeef 0
we_full  data wr 0        80400800 cafef00d f 0        0        0
we_part  data wr 0        80400800 12345678 c 0        0        0
re_part  data rd 0        80400800 0        f 0        1234f00d 0
wi_base  data wr 0        80000040 3c08abcd f 0        0        0
wi_ext   data wr 0        80400040 24090017 f 0        0        0
fetch    inst rd 80001004 0        0        f 99adbeef 0        0
split    both rd 80000040 80400800 0        f 3c08abcd 1234f00d 0
cfl_base both rd 80000040 80001000 0        f 3c08abcd 11bb33dd 1
cfl_ext  both rd 80400040 80400800 0        f 24090017 1234f00d 1
tx_a     data wr 0        bfd003f8 00000141 f 0        41       0
tx_b     data wr 0        bfd003f8 deadbea5 1 0        a5       0
irq_lo   idle -- 0        0        0        0 0        0        0
stat_one both rd 80400040 bfd003fc 0        f 24090017 1        0
rx_byte  rx   -- 0        0        0000005a 0 0        1        0
stat_rdy data rd 0        bfd003fc 0        f 0        3        0
rd_rx    data rd 0        bfd003f8 0        f 0        5a       0
stat_clr data rd 0        bfd003fc 0        f 0        1        0
irq_clr  idle -- 0        0        0        0 0        0        0
un_rd    data rd 0        90000000 0        f 0        0        0
un_top   data rd 0        80800000 0        f 0        0        0
un_fetch inst rd bfc00000 0        0        f 0        0        0
un_wr    data wr 0        90001000 ffffffff f 0        0        0
un_wrf   data wr 0        90000104 ffffffff f 0        0        0
rb_after data rd 0        80001000 0        f 0        11bb33dd 0

// File: test/tb_memory_bus.sv
`timescale 1ns/1ns
`include "bus_config.svh"

module tb_memory_bus import bus_pkg::*; ();

    localparam int PERIOD = 20;
    localparam int SEED   = 11;
    localparam int FILL_N = 4;      // random words per bank
    localparam int MARGIN = 100;

    // one access from the data file
    typedef struct packed {
        logic [95:0]        name;
        logic [63:0]        action;   // inst, data, both, rx or idle
        logic [63:0]        kind;     // rd, wr or --
        logic [`WORD_W-1:0] addr_i;
        logic [`WORD_W-1:0] addr_d;
        logic [`WORD_W-1:0] wdata;
        logic [`MASK_W-1:0] mask;
        logic [`WORD_W-1:0] exp_i;
        logic [`WORD_W-1:0] exp_d;    // also tx byte or irq level
        logic               stall;
    } rec_t;

    logic               clk;
    logic               rst_n;
    mem_req_t           inst_req;
    mem_req_t           data_req;
    mem_rsp_t           inst_rsp;
    mem_rsp_t           data_rsp;
    logic               stall;
    sram_pins_t         base_pins;
    sram_pins_t         ext_pins;
    logic [`WORD_W-1:0] base_din;
    logic [`WORD_W-1:0] ext_din;
    logic               uart_tx_stb;
    logic [`BYTE_W-1:0] uart_tx_data;
    logic               uart_rx_stb;
    logic [`BYTE_W-1:0] uart_rx_data;
    logic               irq;

    rec_t               recs[$];
    logic [`WORD_W-1:0] fill_words [0:2*FILL_N-1];
    integer             seed;
    int                 error_count = 0;
    int                 check_count = 0;
    int                 cycle_count = 0;
    int                 cycle_limit = 0;

    memory_bus_top uut (
        .clk_25m_i      (clk),
        .rst_n_i        (rst_n),
        .inst_req_i     (inst_req),
        .data_req_i     (data_req),
        .inst_rsp_o     (inst_rsp),
        .data_rsp_o     (data_rsp),
        .stall_o        (stall),
        .base_pins_o    (base_pins),
        .base_din_i     (base_din),
        .ext_pins_o     (ext_pins),
        .ext_din_i      (ext_din),
        .uart_tx_stb_o  (uart_tx_stb),
        .uart_tx_data_o (uart_tx_data),
        .uart_rx_stb_i  (uart_rx_stb),
        .uart_rx_data_i (uart_rx_data),
        .irq_o          (irq)
    );

    sram_model base_bank (.clk_i(clk), .pins_i(base_pins), .rdata_o(base_din));
    sram_model ext_bank (.clk_i(clk), .pins_i(ext_pins), .rdata_o(ext_din));

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check_value(input logic [95:0] name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("[ERROR] %0s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic clear_inputs();
        inst_req     = '0;
        data_req     = '0;
        uart_rx_stb  = 1'b0;
        uart_rx_data = '0;
    endtask

    task automatic drive_record(input rec_t r);
        clear_inputs();
        if (r.action == "inst" || r.action == "both") begin
            inst_req.re       = 1'b1;
            inst_req.addr.raw = r.addr_i;
            inst_req.mask     = '1;    // fetches are whole words
        end
        if (r.action == "data" || r.action == "both") begin
            data_req.re       = (r.kind == "rd");
            data_req.we       = (r.kind == "wr");
            data_req.addr.raw = r.addr_d;
            data_req.wdata    = r.wdata;
            data_req.mask     = r.mask;
        end
        if (r.action == "rx") begin
            uart_rx_stb  = 1'b1;
            uart_rx_data = r.wdata[7:0];
        end
    endtask

    // request driven on a falling edge and accepted at edge N
    task automatic run_access(input rec_t r);
        logic inst_rd;
        logic data_rd;
        logic tx_exp;
        inst_rd = (r.action == "inst" || r.action == "both");
        data_rd = (r.action == "data" || r.action == "both") && (r.kind == "rd");
        tx_exp  = (r.action == "data") && (r.kind == "wr") && (r.addr_d == `UART_DATA_ADDR);
        drive_record(r);
        @(negedge clk);
        clear_inputs();
        check_value(r.name, 32'(r.stall), 32'(stall));
        check_value(r.name, 32'(tx_exp), 32'(uart_tx_stb));
        if (tx_exp)
            check_value(r.name, 32'(r.exp_d[7:0]), 32'(uart_tx_data));
        if (r.action == "rx" || r.action == "idle")
            check_value(r.name, 32'(r.exp_d[0]), 32'(irq));
        @(negedge clk);                 // after edge N+1
        check_value(r.name, 32'h0, 32'(stall));         // stall lasts one cycle
        check_value(r.name, 32'h0, 32'(uart_tx_stb));   // tx strobe is a single pulse
        check_value(r.name, 32'(inst_rd), 32'(inst_rsp.rvalid));
        if (inst_rd)
            check_value(r.name, r.exp_i, inst_rsp.rdata);
        if (r.stall) begin
            check_value(r.name, 32'h0, 32'(data_rsp.rvalid));   // held read still out
            @(negedge clk);
        end
        check_value(r.name, 32'(data_rd), 32'(data_rsp.rvalid));
        if (data_rd)
            check_value(r.name, r.exp_d, data_rsp.rdata);
    endtask

    function automatic logic [31:0] fill_address(input int k);
        if (k < FILL_N) begin
            return `BASE_LO + 32'h100 + 32'(k * 4);
        end else begin
            return `EXT_LO + 32'h100 + 32'((k - FILL_N) * 4);
        end
    endfunction

    task automatic fill_pass(input logic write);
        rec_t r;
        for (int k = 0; k < 2 * FILL_N; k++) begin
            r        = '0;
            r.action = "data";
            r.addr_d = fill_address(k);
            r.mask   = '1;
            if (write) begin
                r.name  = "fill_wr";
                r.kind  = "wr";
                r.wdata = fill_words[k];
            end else begin
                r.name  = "fill_rd";
                r.kind  = "rd";
                r.exp_d = fill_words[k];
            end
            run_access(r);
        end
    endtask

    task automatic load_records(input int fd);
        rec_t          r;
        logic [95:0]   token;
        logic [63:0]   act;
        logic [63:0]   kind;
        logic [31:0]   a_i;
        logic [31:0]   a_d;
        logic [31:0]   wd;
        logic [3:0]    mask;
        logic [31:0]   e_i;
        logic [31:0]   e_d;
        logic [31:0]   st;
        logic [1023:0] skip;
        int            n;
        n = $fscanf(fd, "%s", token);
        while (n == 1) begin
            if (token == "#") begin
                n = $fgets(skip, fd);   // column description
            end else begin
                n = $fscanf(fd, "%s %s %h %h %h %h %h %h %d",
                            act, kind, a_i, a_d, wd, mask, e_i, e_d, st);
                if (n != 9) begin
                    error_count++;
                    $display("record %0s in the data file is incomplete", token);
                end
                r = {token, act, kind, a_i, a_d, wd, mask, e_i, e_d, st[0]};
                recs.push_back(r);
            end
            n = $fscanf(fd, "%s", token);
        end
    endtask

    task automatic check_reset();
        check_value("reset", 32'h0, 32'({inst_rsp.rvalid, data_rsp.rvalid, stall,
                    uart_tx_stb, irq, base_pins.doe, ext_pins.doe}));
        check_value("reset_pins", 32'h3f, 32'({base_pins.ce_n, base_pins.oe_n,
                    base_pins.we_n, ext_pins.ce_n, ext_pins.oe_n, ext_pins.we_n}));
    endtask

    initial begin
        int fd;
        clear_inputs();
        rst_n = 1'b0;
        seed  = SEED;
        fd    = $fopen("test/bus_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/bus_testdata.txt, no tests were run");
            $display(">>> FAIL");
            $finish;
        end else begin
            load_records(fd);
            $fclose(fd);
            cycle_limit = (recs.size() + 4 * FILL_N) * 6 + MARGIN;
            for (int k = 0; k < 2 * FILL_N; k++) begin
                fill_words[k] = $random(seed);
            end
            repeat (5) @(posedge clk);
            @(negedge clk);
            check_reset();
            rst_n = 1'b1;
            @(negedge clk);
            fill_pass(1'b1);
            foreach (recs[i]) begin
                run_access(recs[i]);
            end
            fill_pass(1'b0);   // unmapped writes must not have touched these
            $display("checks: %0d, errors: %0d", check_count, error_count);
            if (error_count == 0) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule

// File: test/sram_model.sv
`timescale 1ns/1ns
`include "bus_config.svh"

module sram_model import bus_pkg::*; (
    input  logic               clk_i,
    input  sram_pins_t         pins_i,
    output logic [`WORD_W-1:0] rdata_o
);

    logic [`WORD_W-1:0] mem [0:(1 << `SRAM_AW) - 1];

    // read is combinational while chip and output enable are low
    assign rdata_o = (!pins_i.ce_n && !pins_i.oe_n) ? mem[pins_i.addr] : '0;

    // write lands at the end of the we_n cycle
    always @(posedge clk_i) begin
        if (!pins_i.ce_n && !pins_i.we_n && pins_i.doe) begin
            for (int b = 0; b < `MASK_W; b++) begin
                if (!pins_i.be_n[b]) begin   // one lane per byte enable
                    mem[pins_i.addr][8*b +: 8] <= pins_i.dout[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: source/memory_bus_top.sv
`timescale 1ns/1ns
`include "bus_config.svh"

module memory_bus_top import bus_pkg::*; (
    input  logic               clk_25m_i,
    input  logic               rst_n_i,
    input  mem_req_t           inst_req_i,
    input  mem_req_t           data_req_i,
    output mem_rsp_t           inst_rsp_o,
    output mem_rsp_t           data_rsp_o,
    output logic               stall_o,
    output sram_pins_t         base_pins_o,
    input  logic [`WORD_W-1:0] base_din_i,
    output sram_pins_t         ext_pins_o,
    input  logic [`WORD_W-1:0] ext_din_i,
    output logic               uart_tx_stb_o,
    output logic [`BYTE_W-1:0] uart_tx_data_o,
    input  logic               uart_rx_stb_i,
    input  logic [`BYTE_W-1:0] uart_rx_data_i,
    output logic               irq_o
);

    region_e            inst_region;
    region_e            data_region;
    mem_req_t           base_req;
    mem_req_t           ext_req;
    mem_req_t           uart_req;
    logic [`WORD_W-1:0] base_rdata;
    logic [`WORD_W-1:0] ext_rdata;
    logic [`WORD_W-1:0] uart_rdata;

    addr_decoder decoder (
        .inst_addr_i   (inst_req_i.addr),
        .data_addr_i   (data_req_i.addr),
        .inst_region_o (inst_region),
        .data_region_o (data_region)
    );

    port_arbiter arbiter (
        .clk_25m_i     (clk_25m_i),
        .rst_n_i       (rst_n_i),
        .inst_req_i    (inst_req_i),
        .data_req_i    (data_req_i),
        .inst_region_i (inst_region),
        .data_region_i (data_region),
        .base_req_o    (base_req),
        .ext_req_o     (ext_req),
        .uart_req_o    (uart_req),
        .base_rdata_i  (base_rdata),
        .ext_rdata_i   (ext_rdata),
        .uart_rdata_i  (uart_rdata),
        .inst_rsp_o    (inst_rsp_o),
        .data_rsp_o    (data_rsp_o),
        .stall_o       (stall_o)
    );

    sram_controller base_sram (
        .clk_25m_i (clk_25m_i),
        .rst_n_i   (rst_n_i),
        .req_i     (base_req),
        .rdata_o   (base_rdata),
        .pins_o    (base_pins_o),
        .ram_din_i (base_din_i)
    );

    sram_controller ext_sram (
        .clk_25m_i (clk_25m_i),
        .rst_n_i   (rst_n_i),
        .req_i     (ext_req),
        .rdata_o   (ext_rdata),
        .pins_o    (ext_pins_o),
        .ram_din_i (ext_din_i)
    );

    serial_regs serial (
        .clk_25m_i      (clk_25m_i),
        .rst_n_i        (rst_n_i),
        .req_i          (uart_req),
        .rdata_o        (uart_rdata),
        .uart_tx_stb_o  (uart_tx_stb_o),
        .uart_tx_data_o (uart_tx_data_o),
        .uart_rx_stb_i  (uart_rx_stb_i),
        .uart_rx_data_i (uart_rx_data_i),
        .irq_o          (irq_o)
    );

endmodule

// File: source/serial_regs.sv
`timescale 1ns/1ns
`include "bus_config.svh"

module serial_regs import bus_pkg::*; (
    input  logic               clk_25m_i,
    input  logic               rst_n_i,
    input  mem_req_t           req_i,
    output logic [`WORD_W-1:0] rdata_o,
    output logic               uart_tx_stb_o,
    output logic [`BYTE_W-1:0] uart_tx_data_o,
    input  logic               uart_rx_stb_i,
    input  logic [`BYTE_W-1:0] uart_rx_data_i,
    output logic               irq_o
);

    logic              stat_sel;
    logic              rx_ready_q;
    logic [`BYTE_W-1:0] rx_data_q;
    logic [1:0]        mode;

    // data and status differ only in address bit 2
    assign stat_sel = req_i.addr.fields.word_idx[0];

    // tx ready is always set, no bit-level transmitter behind it
    assign mode = {rx_ready_q, 1'b1};

    assign uart_tx_stb_o  = req_i.we & ~stat_sel;
    assign uart_tx_data_o = req_i.wdata[`BYTE_W-1:0];

    always_ff @(posedge clk_25m_i) begin
        if (uart_rx_stb_i) begin
            rx_data_q <= uart_rx_data_i;
        end
    end

    always_ff @(posedge clk_25m_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_ready_q <= 1'b0;
        end else if (uart_rx_stb_i) begin
            rx_ready_q <= 1'b1;          // new byte beats a same-cycle read
        end else if (req_i.re && !stat_sel) begin
            rx_ready_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_25m_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdata_o <= '0;
        end else if (req_i.re) begin
            if (stat_sel) begin
                rdata_o <= {{(`WORD_W-2){1'b0}}, mode};
            end else begin
                rdata_o <= {{(`WORD_W-`BYTE_W){1'b0}}, rx_data_q};
            end
        end
    end

    assign irq_o = rx_ready_q;

endmodule

// File: source/sram_controller.sv
`timescale 1ns/1ns
`include "bus_config.svh"

module sram_controller import bus_pkg::*; (
    input  logic               clk_25m_i,
    input  logic               rst_n_i,
    input  mem_req_t           req_i,
    output logic [`WORD_W-1:0] rdata_o,
    output sram_pins_t         pins_o,
    input  logic [`WORD_W-1:0] ram_din_i
);

    logic rd;
    logic wr;

    // a write wins if both were ever set
    assign wr = req_i.we;
    assign rd = req_i.re & ~req_i.we;

    // one cycle of strobes per issued request
    always_comb begin
        pins_o.addr = req_i.addr.fields.word_idx;  // byte offset dropped
        pins_o.dout = req_i.wdata;
        pins_o.doe  = wr;                          // drive data only on writes
        pins_o.be_n = ~req_i.mask;
        pins_o.ce_n = ~(rd | wr);
        pins_o.oe_n = ~rd;
        pins_o.we_n = ~wr;
    end

    // read word taken at the end of the access cycle
    always_ff @(posedge clk_25m_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdata_o <= '0;
        end else if (rd) begin
            rdata_o <= ram_din_i;
        end
    end

endmodule

// File: source/port_arbiter.sv
`timescale 1ns/1ns
`include "bus_config.svh"

module port_arbiter import bus_pkg::*; (
    input  logic               clk_25m_i,
    input  logic               rst_n_i,
    input  mem_req_t           inst_req_i,
    input  mem_req_t           data_req_i,
    input  region_e            inst_region_i,
    input  region_e            data_region_i,
    output mem_req_t           base_req_o,
    output mem_req_t           ext_req_o,
    output mem_req_t           uart_req_o,
    input  logic [`WORD_W-1:0] base_rdata_i,
    input  logic [`WORD_W-1:0] ext_rdata_i,
    input  logic [`WORD_W-1:0] uart_rdata_i,
    output mem_rsp_t           inst_rsp_o,
    output mem_rsp_t           data_rsp_o,
    output logic               stall_o
);

    // who answers a port, and whether it answers at all
    typedef struct packed {
        logic    rd;
        region_e src;
    } ret_tag_t;

    logic     inst_act;
    logic     data_act;
    logic     data_is_sram;
    logic     conflict;
    logic     stall_q;
    mem_req_t base_req_d;
    mem_req_t ext_req_d;
    mem_req_t uart_req_d;
    mem_req_t hold_req_q;      // data request postponed by a conflict
    region_e  hold_region_q;
    ret_tag_t inst_tag_d;
    ret_tag_t data_tag_d;
    ret_tag_t inst_tag_q;      // issue stage
    ret_tag_t data_tag_q;
    ret_tag_t inst_ret_q;      // return stage
    ret_tag_t data_ret_q;

    // ports are ignored while the held request goes out
    assign inst_act     = inst_req_i.re & ~stall_q;
    assign data_act     = (data_req_i.re | data_req_i.we) & ~stall_q;
    assign data_is_sram = (data_region_i == REG_BASE) || (data_region_i == REG_EXT);
    assign conflict     = inst_act & data_act & data_is_sram
                        & (inst_region_i == data_region_i);

    always_comb begin
        base_req_d = '0;
        ext_req_d  = '0;
        uart_req_d = '0;
        inst_tag_d = '0;
        data_tag_d = '0;
        if (stall_q) begin
            // second half of a serialised pair
            if (hold_region_q == REG_BASE) begin
                base_req_d = hold_req_q;
            end else begin
                ext_req_d = hold_req_q;
            end
            data_tag_d.rd  = hold_req_q.re;
            data_tag_d.src = hold_region_q;
        end else begin
            if (inst_act) begin
                inst_tag_d.rd  = 1'b1;   // unmapped fetch still answers zero
                inst_tag_d.src = inst_region_i;
                case (inst_region_i)
                    REG_BASE: base_req_d = inst_req_i;
                    REG_EXT:  ext_req_d  = inst_req_i;
                    default: ;
                endcase
            end
            if (data_act && !conflict) begin
                data_tag_d.rd  = data_req_i.re;
                data_tag_d.src = data_region_i;
                case (data_region_i)
                    REG_BASE:                    base_req_d = data_req_i;
                    REG_EXT:                     ext_req_d  = data_req_i;
                    REG_UART_DATA, REG_UART_STAT: uart_req_d = data_req_i;
                    default: ;                   // unmapped write is dropped
                endcase
            end
        end
    end

    always_ff @(posedge clk_25m_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            base_req_o <= '0;
            ext_req_o  <= '0;
            uart_req_o <= '0;
            inst_tag_q <= '0;
            data_tag_q <= '0;
            inst_ret_q <= '0;
            data_ret_q <= '0;
            stall_q    <= 1'b0;
        end else begin
            base_req_o <= base_req_d;
            ext_req_o  <= ext_req_d;
            uart_req_o <= uart_req_d;
            inst_tag_q <= inst_tag_d;
            data_tag_q <= data_tag_d;
            inst_ret_q <= inst_tag_q;   // lines up with the unit capture
            data_ret_q <= data_tag_q;
            stall_q    <= conflict;     // exactly one cycle per conflict
        end
    end

    always_ff @(posedge clk_25m_i) begin
        if (conflict) begin
            hold_req_q    <= data_req_i;
            hold_region_q <= data_region_i;
        end
    end

    function automatic logic [`WORD_W-1:0] pick_word(
        input ret_tag_t           tag,
        input logic [`WORD_W-1:0] base_w,
        input logic [`WORD_W-1:0] ext_w,
        input logic [`WORD_W-1:0] uart_w
    );
        case (tag.src)
            REG_BASE:                    return base_w;
            REG_EXT:                     return ext_w;
            REG_UART_DATA, REG_UART_STAT: return uart_w;
            default:                     return '0;
        endcase
    endfunction

    always_comb begin
        inst_rsp_o.rvalid = inst_ret_q.rd;
        inst_rsp_o.rdata  = pick_word(inst_ret_q, base_rdata_i, ext_rdata_i, uart_rdata_i);
        data_rsp_o.rvalid = data_ret_q.rd;
        data_rsp_o.rdata  = pick_word(data_ret_q, base_rdata_i, ext_rdata_i, uart_rdata_i);
    end

    assign stall_o = stall_q;

endmodule

// File: source/addr_decoder.sv
`timescale 1ns/1ns
`include "bus_config.svh"

module addr_decoder import bus_pkg::*; (
    input  bus_addr_u inst_addr_i,
    input  bus_addr_u data_addr_i,
    output region_e   inst_region_o,
    output region_e   data_region_o
);

    // both sram windows, anything else is unmapped
    function automatic region_e sram_region(input logic [`WORD_W-1:0] addr);
        region_e r;
        r = REG_NONE;
        if (addr >= `BASE_LO && addr <= `BASE_HI) begin
            r = REG_BASE;
        end else if (addr >= `EXT_LO && addr <= `EXT_HI) begin
            r = REG_EXT;
        end
        return r;
    endfunction

    // fetches only ever come from sram
    always_comb begin
        inst_region_o = sram_region(inst_addr_i.raw);
    end

    always_comb begin
        data_region_o = sram_region(data_addr_i.raw);
        if (data_addr_i.raw == `UART_DATA_ADDR) begin
            data_region_o = REG_UART_DATA;
        end else if (data_addr_i.raw == `UART_STAT_ADDR) begin
            data_region_o = REG_UART_STAT;
        end
    end

endmodule

// File: source/bus_pkg.sv
`include "bus_config.svh"

package bus_pkg;

    // target of one access
    typedef enum logic [2:0] {
        REG_NONE,        // unmapped, answers zero
        REG_BASE,
        REG_EXT,
        REG_UART_DATA,
        REG_UART_STAT
    } region_e;

    // one byte address, seen whole or split for the sram pins
    typedef union packed {
        logic [`WORD_W-1:0] raw;
        struct packed {
            logic [9:0]          seg;      // window select bits
            logic [`SRAM_AW-1:0] word_idx;
            logic [1:0]          offset;   // byte within word
        } fields;
    } bus_addr_u;

    // request from a core port, also the issued request into a unit
    typedef struct packed {
        logic               re;
        logic               we;
        bus_addr_u          addr;
        logic [`WORD_W-1:0] wdata;
        logic [`MASK_W-1:0] mask;
    } mem_req_t;

    // read response back to a core port
    typedef struct packed {
        logic               rvalid;
        logic [`WORD_W-1:0] rdata;
    } mem_rsp_t;

    // async sram outputs, data pins split into out and enable
    typedef struct packed {
        logic [`SRAM_AW-1:0] addr;
        logic [`WORD_W-1:0]  dout;
        logic                doe;
        logic [`MASK_W-1:0]  be_n;
        logic                ce_n;
        logic                oe_n;
        logic                we_n;
    } sram_pins_t;

endpackage

// File: source/bus_config.svh
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

// bus widths
`define WORD_W  32
`define MASK_W  4
`define SRAM_AW 20   // word address into one 4 MB bank
`define BYTE_W  8    // serial data byte

// base sram window
`define BASE_LO 32'h8000_0000
`define BASE_HI 32'h803F_FFFF

// ext sram window
`define EXT_LO  32'h8040_0000
`define EXT_HI  32'h807F_FFFF

// serial register pair, one word apart
`define UART_DATA_ADDR 32'hBFD0_03F8
`define UART_STAT_ADDR 32'hBFD0_03FC

`endif
